// ==== dv/tb_matrix_ctrl.sv ====
`timescale 1ns/1ns
`include "matrix_ctrl_params.svh"

module tb_matrix_ctrl
    import matrix_ctrl_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int NUM_TESTS  = 6;
    localparam int WAIT_BOUND = 50;

    logic       clk;
    logic       rst_n;
    logic [7:0] i_sw;
    logic [2:0] i_btn;
    logic       i_dims_valid;
    dim_t       i_dim_m;
    dim_t       i_dim_n;
    logic       i_rx_done;
    logic       i_id_valid;
    dim_t       i_id_val;
    logic       i_timeout;
    logic       i_calc_done;
    logic [7:0] o_led;
    state_e     o_state;
    logic       o_logic_error;
    logic       o_en_input;
    logic       o_is_gen_mode;
    task_mode_e o_task_mode;
    logic       o_addr_ready;
    addr_t      o_base_addr;
    logic       o_start_calc;
    op_e        o_op_code;
    addr_t      o_op1_addr;
    addr_t      o_op2_addr;
    dim_t       o_op1_m;
    dim_t       o_op1_n;
    dim_t       o_op2_m;
    dim_t       o_op2_n;
    addr_t      o_res_addr;
    type_idx_t  o_types_count;

    // reference copy of the shape table
    int ent_m     [`MC_MAX_TYPES];
    int ent_n     [`MC_MAX_TYPES];
    int ent_start [`MC_MAX_TYPES];
    int ent_tog   [`MC_MAX_TYPES];
    int ent_cnt   [`MC_MAX_TYPES];
    int ent_count;
    int free_ptr;

    logic [7:0] lfsr_q;
    int a_m;
    int a_n;
    int b_m;
    int b_n;

    matrix_ctrl_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==============================
    // helpers
    // ==============================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // inputs change a little after the rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic press(input int b);
        step();
        i_btn[b] = 1'b1;
        repeat (`MC_DEBOUNCE + 2) step();
        i_btn[b] = 1'b0;
    endtask

    task automatic wait_state(input state_e s);
        int cycles;
        cycles = 0;
        while (o_state !== s && cycles < WAIT_BOUND) begin
            step();
            cycles++;
        end
        if (o_state !== s) begin
            abort_run($sformatf("controller never reached %s within %0d cycles",
                                s.name(), WAIT_BOUND));
        end
    endtask

    task automatic wait_start_calc();
        int cycles;
        cycles = 0;
        while (o_start_calc !== 1'b1 && cycles < WAIT_BOUND) begin
            step();
            cycles++;
        end
        if (o_start_calc !== 1'b1) begin
            abort_run("calculator start was never raised in S_EXECUTE");
        end
    endtask

    // 8-bit fibonacci with taps 8 6 5 4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic pick_dim(output int d);
        logic [1:0] v;
        for (int b = 0; b < 2; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v[b]   = lfsr_q[0];
        end
        d = int'(v) + 1;
    endtask

    // ==============================
    // ledger reference
    // ==============================
    function automatic int find_entry(input int m, input int n);
        int idx;
        idx = -1;
        for (int i = 0; i < ent_count; i++) begin
            if (ent_m[i] == m && ent_n[i] == n) idx = i;
        end
        return idx;
    endfunction

    function automatic int predict_addr(input int m, input int n);
        int idx;
        idx = find_entry(m, n);
        if (idx < 0) return free_ptr & 'h1FF;
        if (ent_tog[idx] != 0) return (ent_start[idx] + m * n) & 'h1FF;
        return ent_start[idx] & 'h1FF;
    endfunction

    function automatic int operand_addr(input int m, input int n, input int id);
        int idx;
        idx = find_entry(m, n);
        return (ent_start[idx] + (id - 1) * m * n) & 'h1FF;
    endfunction

    task automatic record_commit(input int m, input int n);
        int idx;
        idx = find_entry(m, n);
        if (idx >= 0) begin
            ent_tog[idx] = 1 - ent_tog[idx];
            if (ent_cnt[idx] < `MC_SLOTS) ent_cnt[idx]++;
        end else if (ent_count < `MC_MAX_TYPES) begin
            ent_m[ent_count]     = m;
            ent_n[ent_count]     = n;
            ent_start[ent_count] = free_ptr;
            ent_tog[ent_count]   = 1;
            ent_cnt[ent_count]   = 1;
            ent_count++;
            free_ptr = free_ptr + 2 * m * n;
        end
    endtask

    // ==============================
    // stimulus sequences
    // ==============================
    task automatic enter_shape(input int m, input int n);
        int exp;
        exp          = predict_addr(m, n);
        i_dim_m      = dim_t'(m);
        i_dim_n      = dim_t'(n);
        i_dims_valid = 1'b1;
        step();
        i_dims_valid = 1'b0;
        check_eq("o_addr_ready", o_addr_ready, 1);
        check_eq("o_base_addr", o_base_addr, exp);
        record_commit(m, n);
        step();
        check_eq("o_addr_ready", o_addr_ready, 0);
    endtask

    task automatic give_operand(input int m, input int n, input int id, input state_e next);
        i_dim_m      = dim_t'(m);
        i_dim_n      = dim_t'(n);
        i_dims_valid = 1'b1;
        step();
        i_dims_valid = 1'b0;
        check_eq("o_state", o_state, S_FILTER);
        step();
        check_eq("o_state", o_state, S_GET_ID);
        check_eq("o_task_mode", o_task_mode, TASK_ID);
        i_id_val   = dim_t'(id);
        i_id_valid = 1'b1;
        step();
        i_id_valid = 1'b0;
        check_eq("o_state", o_state, next);
        check_eq("o_logic_error", o_logic_error, 0);
    endtask

    task automatic run_calc(input int m, input int n);
        int exp;
        wait_start_calc();
        exp = predict_addr(m, n);
        check_eq("o_res_addr", o_res_addr, exp);
        repeat (3) begin
            step();
            check_eq("o_start_calc", o_start_calc, 1);
        end
        i_calc_done = 1'b1;
        step();
        i_calc_done = 1'b0;
        record_commit(m, n);
        check_eq("o_start_calc", o_start_calc, 0);
        check_eq("o_state", o_state, S_DECIDE);
        check_eq("o_led", o_led, `MC_LED_DECIDE);
    endtask

    // ==============================
    // tests
    // ==============================
    task automatic reset_values();
        rst_n = 1'b0;
        repeat (10) step();
        rst_n = 1'b1;
        check_eq("o_state", o_state, S_IDLE);
        check_eq("o_en_input", o_en_input, 0);
        check_eq("o_start_calc", o_start_calc, 0);
        check_eq("o_logic_error", o_logic_error, 0);
        check_eq("o_addr_ready", o_addr_ready, 0);
        step();
        check_eq("o_led", o_led, `MC_LED_IDLE);
    endtask

    task automatic entry_allocation();
        i_sw = 8'h00;
        press(0);
        wait_state(S_INPUT);
        check_eq("o_led", o_led, `MC_LED_INPUT);
        check_eq("o_en_input", o_en_input, 1);
        check_eq("o_is_gen_mode", o_is_gen_mode, 0);
        check_eq("o_task_mode", o_task_mode, TASK_DIMS);
        repeat (3) enter_shape(a_m, a_n);
        enter_shape(b_m, b_n);
        check_eq("o_types_count", o_types_count, 2);
        i_rx_done = 1'b1;
        step();
        i_rx_done = 1'b0;
        wait_state(S_DECIDE);
        press(0);
        wait_state(S_IDLE);
    endtask

    task automatic add_calculation();
        i_sw = {3'b001, 3'b000, 2'b10};
        press(0);
        wait_state(S_SELECT_OP);
        press(0);
        wait_state(S_GET_DIM);
        check_eq("o_task_mode", o_task_mode, TASK_OP_DIMS);
        check_eq("o_op_code", o_op_code, OP_ADD);
        give_operand(a_m, a_n, 2, S_GET_DIM);
        check_eq("o_op1_addr", o_op1_addr, operand_addr(a_m, a_n, 2));
        check_eq("o_op1_m", o_op1_m, a_m);
        check_eq("o_op1_n", o_op1_n, a_n);
        give_operand(a_m, a_n, 1, S_EXECUTE);
        check_eq("o_op2_addr", o_op2_addr, operand_addr(a_m, a_n, 1));
        check_eq("o_op2_m", o_op2_m, a_m);
        check_eq("o_op2_n", o_op2_n, a_n);
        check_eq("o_start_calc", o_start_calc, 0);
        step();
        check_eq("o_start_calc", o_start_calc, 1);
        run_calc(a_m, a_n);
        press(0);
        wait_state(S_IDLE);
    endtask

    task automatic transpose_and_scalar();
        // transpose with one operand and a swapped result shape
        i_sw = {3'b000, 3'b000, 2'b10};
        press(0);
        wait_state(S_SELECT_OP);
        press(0);
        wait_state(S_GET_DIM);
        give_operand(b_m, b_n, 1, S_EXECUTE);
        check_eq("o_op1_addr", o_op1_addr, operand_addr(b_m, b_n, 1));
        run_calc(b_n, b_m);
        press(0);
        wait_state(S_IDLE);

        // scalar op
        i_sw = {3'b010, 3'b000, 2'b10};
        press(0);
        wait_state(S_SELECT_OP);
        press(0);
        wait_state(S_GET_DIM);
        give_operand(a_m, a_n, 1, S_GET_SCALAR);
        i_sw = 8'h52;
        press(0);
        wait_state(S_EXECUTE);
        check_eq("o_op_code", o_op_code, OP_SCALAR);
        check_eq("o_op2_m", o_op2_m, 5);
        run_calc(a_m, a_n);
        press(0);
        wait_state(S_IDLE);
    endtask

    task automatic error_paths();
        i_sw = {3'b001, 3'b000, 2'b10};
        press(0);
        wait_state(S_SELECT_OP);
        press(0);
        wait_state(S_GET_DIM);
        // width 5 never occurs in the table
        i_dim_m      = dim_t'(5);
        i_dim_n      = dim_t'(1);
        i_dims_valid = 1'b1;
        step();
        i_dims_valid = 1'b0;
        check_eq("o_state", o_state, S_FILTER);
        step();
        check_eq("o_state", o_state, S_GET_DIM);
        check_eq("o_logic_error", o_logic_error, 1);

        i_dim_m      = dim_t'(a_m);
        i_dim_n      = dim_t'(a_n);
        i_dims_valid = 1'b1;
        step();
        i_dims_valid = 1'b0;
        step();
        check_eq("o_state", o_state, S_GET_ID);
        i_id_val   = dim_t'(0);
        i_id_valid = 1'b1;
        step();
        i_id_valid = 1'b0;
        check_eq("o_state", o_state, S_GET_ID);
        check_eq("o_logic_error", o_logic_error, 1);

        // one past the stored count of that shape
        i_id_val   = dim_t'(ent_cnt[find_entry(a_m, a_n)] + 1);
        i_id_valid = 1'b1;
        step();
        i_id_valid = 1'b0;
        check_eq("o_state", o_state, S_GET_ID);
        check_eq("o_logic_error", o_logic_error, 1);
        press(2);
        wait_state(S_IDLE);

        // timeout while entering
        i_sw = 8'h00;
        press(0);
        wait_state(S_INPUT);
        i_timeout = 1'b1;
        step();
        i_timeout = 1'b0;
        check_eq("o_state", o_state, S_ERROR);
        check_eq("o_led", o_led, `MC_LED_ERROR);
        press(0);
        wait_state(S_IDLE);
        check_eq("o_led", o_led, `MC_LED_IDLE);
    endtask

    task automatic menu_navigation();
        i_sw = {3'b001, 3'b000, 2'b10};
        press(0);
        wait_state(S_SELECT_OP);
        press(0);
        wait_state(S_GET_DIM);
        press(2);
        wait_state(S_IDLE);

        i_sw = 8'h01;
        press(0);
        wait_state(S_GEN);
        check_eq("o_is_gen_mode", o_is_gen_mode, 1);
        check_eq("o_led", o_led, `MC_LED_GEN);
        i_rx_done = 1'b1;
        step();
        i_rx_done = 1'b0;
        wait_state(S_DECIDE);
        press(1);
        wait_state(S_GEN);
        check_eq("o_led", o_led, `MC_LED_GEN);
        i_rx_done = 1'b1;
        step();
        i_rx_done = 1'b0;
        wait_state(S_DECIDE);
        press(0);
        wait_state(S_IDLE);
    endtask

    // ==============================
    // main sequence and watchdog
    // ==============================
    initial begin
        rst_n        = 1'b0;
        i_sw         = 8'h00;
        i_btn        = 3'b000;
        i_dims_valid = 1'b0;
        i_dim_m      = '0;
        i_dim_n      = '0;
        i_rx_done    = 1'b0;
        i_id_valid   = 1'b0;
        i_id_val     = '0;
        i_timeout    = 1'b0;
        i_calc_done  = 1'b0;
        ent_count    = 0;
        free_ptr     = 0;
        lfsr_q       = 8'd56;

        pick_dim(a_m);
        pick_dim(a_n);
        b_m = a_m;
        b_n = a_n;
        while (b_m == a_m && b_n == a_n) begin
            pick_dim(b_m);
            pick_dim(b_n);
        end

        reset_values();
        entry_allocation();
        add_calculation();
        transpose_and_scalar();
        error_paths();
        menu_navigation();

        $display("Verification passed");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        abort_run("simulation exceeded its time budget, the controller seems stuck");
    end

endmodule

// ==== src/ctrl_fsm.sv ====
`timescale 1ns/1ns
`include "matrix_ctrl_params.svh"

module ctrl_fsm
    import matrix_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       i_confirm,
    input  logic       i_retry,
    input  logic       i_menu,
    input  logic [7:0] i_sw,
    input  logic       i_dims_valid,
    input  logic       i_rx_done,
    input  logic       i_id_valid,
    input  logic       i_timeout,
    input  logic       i_calc_done,
    input  dim_t       i_id_val,
    input  logic       i_found,
    input  logic [1:0] i_sel_count,
    output state_e     o_state,
    output logic       o_en_input,
    output logic       o_is_gen_mode,
    output task_mode_e o_task_mode,
    output logic       o_addr_ready,
    output logic       o_commit,
    output logic       o_sel_latch,
    output logic       o_load_op1,
    output logic       o_load_op2,
    output logic       o_load_scalar,
    output logic       o_start_calc,
    output op_e        o_op_code,
    output logic       o_logic_error,
    output logic [7:0] o_led
);

    state_e state_q;
    state_e next_state;
    state_e retry_q;
    logic   stage_q;
    logic   is_entry;
    logic   id_ok;

    assign o_state  = state_q;
    assign is_entry = (state_q == S_INPUT) || (state_q == S_GEN);
    assign id_ok    = (state_q == S_GET_ID) && i_id_valid && (i_id_val != '0)
                      && (i_id_val <= dim_t'(i_sel_count));

    assign o_commit      = (is_entry && i_dims_valid) || (state_q == S_EXECUTE && i_calc_done);
    assign o_sel_latch   = (state_q == S_FILTER) && i_found;
    assign o_load_op1    = id_ok && !stage_q;
    assign o_load_op2    = id_ok && stage_q;
    assign o_load_scalar = (state_q == S_GET_SCALAR) && i_confirm;

    // ==============================
    // next state
    // ==============================
    always_comb begin
        next_state = state_q;
        if (state_q != S_IDLE && i_menu) begin
            next_state = S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_confirm) begin
                        case (i_sw[1:0])
                            2'b00:   next_state = S_INPUT;
                            2'b01:   next_state = S_GEN;
                            2'b10:   next_state = S_SELECT_OP;
                            default: next_state = S_IDLE;
                        endcase
                    end
                end
                S_INPUT, S_GEN: begin
                    if (i_rx_done) next_state = S_DECIDE;
                    else if (i_timeout) next_state = S_ERROR;
                end
                S_SELECT_OP: if (i_confirm) next_state = S_GET_DIM;
                S_GET_DIM: begin
                    if (i_timeout) next_state = S_ERROR;
                    else if (i_dims_valid) next_state = S_FILTER;
                end
                S_FILTER: next_state = i_found ? S_GET_ID : S_GET_DIM;
                S_GET_ID: begin
                    if (i_timeout) begin
                        next_state = S_ERROR;
                    end else if (id_ok) begin
                        if (o_op_code == OP_TRANSPOSE || stage_q) next_state = S_EXECUTE;
                        else if (o_op_code == OP_SCALAR) next_state = S_GET_SCALAR;
                        else next_state = S_GET_DIM;
                    end
                end
                S_GET_SCALAR: if (i_confirm) next_state = S_EXECUTE;
                S_EXECUTE: if (i_calc_done) next_state = S_DECIDE;
                S_DECIDE: begin
                    if (i_confirm) next_state = S_IDLE;
                    else if (i_retry) next_state = retry_q;
                end
                S_ERROR: if (i_confirm) next_state = S_IDLE;
                default: next_state = S_IDLE;
            endcase
        end
    end

    // ==============================
    // registers and outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= S_IDLE;
            retry_q       <= S_IDLE;
            stage_q       <= 1'b0;
            o_op_code     <= OP_TRANSPOSE;
            o_en_input    <= 1'b0;
            o_is_gen_mode <= 1'b0;
            o_task_mode   <= TASK_DIMS;
            o_addr_ready  <= 1'b0;
            o_start_calc  <= 1'b0;
            o_logic_error <= 1'b0;
            o_led         <= 8'h00;
        end else begin
            state_q <= next_state;

            // remembered for retry
            if (state_q == S_IDLE && next_state != S_IDLE) begin
                retry_q <= next_state;
            end

            if (state_q == S_SELECT_OP && i_confirm) begin
                o_op_code <= op_e'(i_sw[7:5]);
                stage_q   <= 1'b0;
            end else if (o_load_op1) begin
                stage_q <= 1'b1;
            end

            o_en_input    <= (next_state == S_INPUT) || (next_state == S_GEN)
                             || (next_state == S_GET_DIM) || (next_state == S_GET_ID);
            o_is_gen_mode <= (next_state == S_GEN);
            o_task_mode   <= (next_state == S_GET_DIM) ? TASK_OP_DIMS :
                             (next_state == S_GET_ID)  ? TASK_ID : TASK_DIMS;
            o_addr_ready  <= is_entry && i_dims_valid;
            // stays up until done or menu
            o_start_calc  <= (state_q == S_EXECUTE) && (next_state == S_EXECUTE);

            if (state_q == S_IDLE || (state_q == S_GET_DIM && i_dims_valid) || id_ok) begin
                o_logic_error <= 1'b0;
            end else if ((state_q == S_FILTER && !i_found)
                         || (state_q == S_GET_ID && i_id_valid)) begin
                o_logic_error <= 1'b1;
            end

            case (next_state)
                S_IDLE:   o_led <= `MC_LED_IDLE;
                S_INPUT:  o_led <= `MC_LED_INPUT;
                S_GEN:    o_led <= `MC_LED_GEN;
                S_DECIDE: o_led <= `MC_LED_DECIDE;
                S_ERROR:  o_led <= `MC_LED_ERROR;
                default:  o_led <= `MC_LED_CALC;
            endcase
        end
    end

endmodule

// ==== src/key_filter.sv ====
`timescale 1ns/1ns
`include "matrix_ctrl_params.svh"

module key_filter (
    input  logic clk,
    input  logic rst_n,
    input  logic i_key,
    output logic o_press
);

    localparam int CNT_W = $clog2(`MC_DEBOUNCE + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             stable;
    logic             level_q;

    assign stable = (cnt_q == CNT_W'(`MC_DEBOUNCE));

    // count consecutive high samples, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (!i_key) begin
            cnt_q <= '0;
        end else if (!stable) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // one pulse per debounced rising edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= 1'b0;
            o_press <= 1'b0;
        end else begin
            level_q <= stable;
            o_press <= stable & ~level_q;
        end
    end

endmodule

// ==== src/matrix_ctrl_params.svh ====
`ifndef MATRIX_CTRL_PARAMS_SVH
`define MATRIX_CTRL_PARAMS_SVH

// ==============================
// widths and sizes
// ==============================
`define MC_DIM_W        8
`define MC_ADDR_W       9
`define MC_MAX_TYPES    25
`define MC_TYPE_IDX_W   5
`define MC_SLOTS        2
`define MC_DEBOUNCE     4

// ==============================
// led codes
// ==============================
`define MC_LED_IDLE     8'h01
`define MC_LED_INPUT    8'h02
`define MC_LED_GEN      8'h04
`define MC_LED_CALC     8'h08
`define MC_LED_DECIDE   8'h80
`define MC_LED_ERROR    8'hFF

`endif

// ==== src/matrix_ctrl_pkg.sv ====
`include "matrix_ctrl_params.svh"

package matrix_ctrl_pkg;

    typedef logic [`MC_DIM_W-1:0]      dim_t;
    typedef logic [`MC_ADDR_W-1:0]     addr_t;
    typedef logic [`MC_TYPE_IDX_W-1:0] type_idx_t;

    // codes 4..7 are treated as add
    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'd0,
        OP_ADD       = 3'd1,
        OP_SCALAR    = 3'd2,
        OP_MATMUL    = 3'd3
    } op_e;

    // what the input subsystem collects
    typedef enum logic [1:0] {
        TASK_DIMS    = 2'd0,
        TASK_OP_DIMS = 2'd1,
        TASK_ID      = 2'd2
    } task_mode_e;

    typedef enum logic [4:0] {
        S_IDLE, S_INPUT, S_GEN, S_SELECT_OP, S_GET_DIM, S_FILTER,
        S_GET_ID, S_GET_SCALAR, S_EXECUTE, S_DECIDE, S_ERROR
    } state_e;

endpackage

// ==== src/matrix_ctrl_top.sv ====
`timescale 1ns/1ns

module matrix_ctrl_top
    import matrix_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] i_sw,
    input  logic [2:0] i_btn,
    input  logic       i_dims_valid,
    input  dim_t       i_dim_m,
    input  dim_t       i_dim_n,
    input  logic       i_rx_done,
    input  logic       i_id_valid,
    input  dim_t       i_id_val,
    input  logic       i_timeout,
    input  logic       i_calc_done,
    output logic [7:0] o_led,
    output state_e     o_state,
    output logic       o_logic_error,
    output logic       o_en_input,
    output logic       o_is_gen_mode,
    output task_mode_e o_task_mode,
    output logic       o_addr_ready,
    output addr_t      o_base_addr,
    output logic       o_start_calc,
    output op_e        o_op_code,
    output addr_t      o_op1_addr,
    output addr_t      o_op2_addr,
    output dim_t       o_op1_m,
    output dim_t       o_op1_n,
    output dim_t       o_op2_m,
    output dim_t       o_op2_n,
    output addr_t      o_res_addr,
    output type_idx_t  o_types_count
);

    logic       confirm;
    logic       retry;
    logic       menu;
    logic       commit;
    logic       sel_latch;
    logic       found;
    type_idx_t  found_idx;
    addr_t      sel_start;
    logic [1:0] sel_count;
    logic       load_op1;
    logic       load_op2;
    logic       load_scalar;
    dim_t       res_m;
    dim_t       res_n;
    dim_t       search_m;
    dim_t       search_n;
    addr_t      hit_addr;

    key_filter u_key_confirm (.clk(clk), .rst_n(rst_n), .i_key(i_btn[0]), .o_press(confirm));
    key_filter u_key_retry   (.clk(clk), .rst_n(rst_n), .i_key(i_btn[1]), .o_press(retry));
    key_filter u_key_menu    (.clk(clk), .rst_n(rst_n), .i_key(i_btn[2]), .o_press(menu));

    // result shape is looked up during execute, entry shape otherwise
    assign search_m    = (o_state == S_EXECUTE) ? res_m : i_dim_m;
    assign search_n    = (o_state == S_EXECUTE) ? res_n : i_dim_n;
    assign o_base_addr = hit_addr;
    assign o_res_addr  = hit_addr;

    // dims from the input subsystem hold until the next entry
    shape_ledger u_ledger (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_search_m    (search_m),
        .i_search_n    (search_n),
        .o_hit         (),
        .o_hit_addr    (hit_addr),
        .i_commit      (commit),
        .i_filter_m    (i_dim_m),
        .i_filter_n    (i_dim_n),
        .o_found       (found),
        .o_found_idx   (found_idx),
        .i_sel_latch   (sel_latch),
        .i_sel_idx     (found_idx),
        .o_sel_start   (sel_start),
        .o_sel_count   (sel_count),
        .o_types_count (o_types_count)
    );

    operand_builder u_builder (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_op_code     (o_op_code),
        .i_load_op1    (load_op1),
        .i_load_op2    (load_op2),
        .i_load_scalar (load_scalar),
        .i_dim_m       (i_dim_m),
        .i_dim_n       (i_dim_n),
        .i_slot_start  (sel_start),
        .i_id          (i_id_val[1:0]),
        .i_scalar      (i_sw[7:4]),
        .o_op1_addr    (o_op1_addr),
        .o_op2_addr    (o_op2_addr),
        .o_op1_m       (o_op1_m),
        .o_op1_n       (o_op1_n),
        .o_op2_m       (o_op2_m),
        .o_op2_n       (o_op2_n),
        .o_res_m       (res_m),
        .o_res_n       (res_n)
    );

    ctrl_fsm u_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_confirm     (confirm),
        .i_retry       (retry),
        .i_menu        (menu),
        .i_sw          (i_sw),
        .i_dims_valid  (i_dims_valid),
        .i_rx_done     (i_rx_done),
        .i_id_valid    (i_id_valid),
        .i_timeout     (i_timeout),
        .i_calc_done   (i_calc_done),
        .i_id_val      (i_id_val),
        .i_found       (found),
        .i_sel_count   (sel_count),
        .o_state       (o_state),
        .o_en_input    (o_en_input),
        .o_is_gen_mode (o_is_gen_mode),
        .o_task_mode   (o_task_mode),
        .o_addr_ready  (o_addr_ready),
        .o_commit      (commit),
        .o_sel_latch   (sel_latch),
        .o_load_op1    (load_op1),
        .o_load_op2    (load_op2),
        .o_load_scalar (load_scalar),
        .o_start_calc  (o_start_calc),
        .o_op_code     (o_op_code),
        .o_logic_error (o_logic_error),
        .o_led         (o_led)
    );

endmodule

// ==== src/operand_builder.sv ====
`timescale 1ns/1ns
`include "matrix_ctrl_params.svh"

module operand_builder
    import matrix_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  op_e        i_op_code,
    input  logic       i_load_op1,
    input  logic       i_load_op2,
    input  logic       i_load_scalar,
    input  dim_t       i_dim_m,
    input  dim_t       i_dim_n,
    input  addr_t      i_slot_start,
    input  logic [1:0] i_id,
    input  logic [3:0] i_scalar,
    output addr_t      o_op1_addr,
    output addr_t      o_op2_addr,
    output dim_t       o_op1_m,
    output dim_t       o_op1_n,
    output dim_t       o_op2_m,
    output dim_t       o_op2_n,
    output dim_t       o_res_m,
    output dim_t       o_res_n
);

    logic [2*`MC_DIM_W-1:0] prod;
    addr_t                  mat_size;
    addr_t                  id_ofs;
    addr_t                  slot_addr;
    dim_t                   op2_m_q;
    logic [3:0]             scalar_q;

    // id counts from 1 within the shape's slots
    assign prod      = i_dim_m * i_dim_n;
    assign mat_size  = prod[`MC_ADDR_W-1:0];
    assign id_ofs    = addr_t'(i_id) - addr_t'(1);
    assign slot_addr = i_slot_start + mat_size * id_ofs;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_op1_addr <= '0;
            o_op1_m    <= '0;
            o_op1_n    <= '0;
            o_op2_addr <= '0;
            op2_m_q    <= '0;
            o_op2_n    <= '0;
            scalar_q   <= '0;
        end else begin
            if (i_load_op1) begin
                o_op1_addr <= slot_addr;
                o_op1_m    <= i_dim_m;
                o_op1_n    <= i_dim_n;
            end
            if (i_load_op2) begin
                o_op2_addr <= slot_addr;
                op2_m_q    <= i_dim_m;
                o_op2_n    <= i_dim_n;
            end
            if (i_load_scalar) begin
                scalar_q <= i_scalar;
            end
        end
    end

    // scalar rides on op2_m for the scalar op
    assign o_op2_m = (i_op_code == OP_SCALAR) ? dim_t'(scalar_q) : op2_m_q;

    // predicted result shape
    assign o_res_m = (i_op_code == OP_TRANSPOSE) ? o_op1_n : o_op1_m;
    assign o_res_n = (i_op_code == OP_TRANSPOSE) ? o_op1_m : o_op1_n;

endmodule

// ==== src/shape_ledger.sv ====
`timescale 1ns/1ns
`include "matrix_ctrl_params.svh"

module shape_ledger
    import matrix_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  dim_t       i_search_m,
    input  dim_t       i_search_n,
    output logic       o_hit,
    output addr_t      o_hit_addr,
    input  logic       i_commit,
    input  dim_t       i_filter_m,
    input  dim_t       i_filter_n,
    output logic       o_found,
    output type_idx_t  o_found_idx,
    input  logic       i_sel_latch,
    input  type_idx_t  i_sel_idx,
    output addr_t      o_sel_start,
    output logic [1:0] o_sel_count,
    output type_idx_t  o_types_count
);

    dim_t       m_q     [`MC_MAX_TYPES];
    dim_t       n_q     [`MC_MAX_TYPES];
    addr_t      start_q [`MC_MAX_TYPES];
    logic       tog_q   [`MC_MAX_TYPES];
    logic [1:0] cnt_q   [`MC_MAX_TYPES];
    type_idx_t  count_q;
    addr_t      free_q;
    type_idx_t  sel_q;

    type_idx_t              hit_idx;
    logic [2*`MC_DIM_W-1:0] search_prod;
    addr_t                  search_size;
    addr_t                  search_addr;
    logic                   full;

    assign search_prod   = i_search_m * i_search_n;
    assign search_size   = search_prod[`MC_ADDR_W-1:0];
    assign full          = (count_q == type_idx_t'(`MC_MAX_TYPES));
    assign o_types_count = count_q;
    assign o_sel_start   = start_q[sel_q];
    assign o_sel_count   = cnt_q[sel_q];

    // ==============================
    // lookup
    // ==============================
    always_comb begin
        o_hit   = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `MC_MAX_TYPES; i++) begin
            if (type_idx_t'(i) < count_q && m_q[i] == i_search_m && n_q[i] == i_search_n) begin
                o_hit   = 1'b1;
                hit_idx = type_idx_t'(i);
            end
        end
    end

    // toggle picks which of the two slots is written next
    assign search_addr = !o_hit          ? free_q :
                         tog_q[hit_idx] ? start_q[hit_idx] + search_size :
                                          start_q[hit_idx];

    // last entry of that shape still holding data
    always_comb begin
        o_found     = 1'b0;
        o_found_idx = '0;
        for (int i = 0; i < `MC_MAX_TYPES; i++) begin
            if (type_idx_t'(i) < count_q && m_q[i] == i_filter_m && n_q[i] == i_filter_n
                    && cnt_q[i] != 2'd0) begin
                o_found     = 1'b1;
                o_found_idx = type_idx_t'(i);
            end
        end
    end

    // ==============================
    // commit
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            free_q  <= '0;
            sel_q   <= '0;
            for (int i = 0; i < `MC_MAX_TYPES; i++) begin
                tog_q[i] <= 1'b0;
                cnt_q[i] <= 2'd0;
            end
        end else begin
            if (i_sel_latch) begin
                sel_q <= i_sel_idx;
            end
            if (i_commit && o_hit) begin
                tog_q[hit_idx] <= ~tog_q[hit_idx];
                if (cnt_q[hit_idx] < `MC_SLOTS) begin
                    cnt_q[hit_idx] <= cnt_q[hit_idx] + 2'd1;
                end
            end else if (i_commit && !full) begin
                tog_q[count_q] <= 1'b1;
                cnt_q[count_q] <= 2'd1;
                free_q         <= free_q + {search_size[`MC_ADDR_W-2:0], 1'b0};
                count_q        <= count_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_commit && !o_hit && !full) begin
            m_q[count_q]     <= i_search_m;
            n_q[count_q]     <= i_search_n;
            start_q[count_q] <= free_q;
        end
        o_hit_addr <= search_addr;
    end

endmodule

// ==== tb.f ====
+incdir+src
src/matrix_ctrl_pkg.sv
src/key_filter.sv
src/shape_ledger.sv
src/operand_builder.sv
src/ctrl_fsm.sv
src/matrix_ctrl_top.sv
dv/tb_matrix_ctrl.sv
